//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_axi_cache_bridge
RTL_TOP    := axi_cache_bridge
FILELIST   := tb.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "=== PASS ===" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          ar_stall,
    input  logic                          aw_stall,
    input  logic                          w_stall,
    input  bridge_pkg::id_t               arid,
    input  logic [bridge_pkg::addr_w-1:0] araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output bridge_pkg::id_t               rid,
    output bridge_pkg::line_t             rdata,
    output logic                          rvalid,
    input  logic                          rready,
    input  logic [bridge_pkg::addr_w-1:0] awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  bridge_pkg::line_t             wdata,
    input  logic [bridge_pkg::strb_w-1:0] wstrb,
    input  logic                          wvalid,
    output logic                          wready,
    output logic                          bvalid,
    input  logic                          bready
);

    localparam int depth = 64;
    localparam int rd_w  = bridge_pkg::id_w + bridge_pkg::data_w;

    bridge_pkg::line_t             mem [depth];
    logic [rd_w-1:0]               rd_q [$];
    logic [rd_w-1:0]               head;
    logic                          aw_got;
    logic                          w_got;
    logic [bridge_pkg::addr_w-1:0] aw_addr;
    bridge_pkg::line_t             w_data;
    logic [bridge_pkg::strb_w-1:0] w_strb;

    // every lane mixes the full byte address of the line
    function automatic bridge_pkg::line_t fill_word(logic [31:0] a);
        return {a ^ 32'hc3c3_0003, a ^ 32'h3c3c_0002, a ^ 32'h0f0f_0001, a ^ 32'hf0f0_0000};
    endfunction

    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = fill_word(32'(i * 16));
        end
    end

    assign arready = !ar_stall;
    // single write in flight, next AW/W waits until B is gone
    assign awready = !aw_stall && !aw_got && !bvalid;
    assign wready  = !w_stall && !w_got && !bvalid;

    always @(posedge clk) begin
        if (reset) begin
            rvalid <= 1'b0;
            bvalid <= 1'b0;
            aw_got <= 1'b0;
            w_got  <= 1'b0;
            rd_q.delete();
        end else begin
            // read data is taken when the address is accepted
            if (arvalid && arready) begin
                rd_q.push_back({arid, mem[araddr[9:4]]});
            end
            if (!rvalid || rready) begin
                if (rd_q.size() > 0) begin
                    head = rd_q.pop_front();
                    rid    <= head[rd_w-1:bridge_pkg::data_w];
                    rdata  <= head[bridge_pkg::data_w-1:0];
                    rvalid <= 1'b1;
                end else begin
                    rvalid <= 1'b0;
                end
            end
            if (awvalid && awready) begin
                aw_got  <= 1'b1;
                aw_addr <= awaddr;
            end
            if (wvalid && wready) begin
                w_got  <= 1'b1;
                w_data <= wdata;
                w_strb <= wstrb;
            end
            if (aw_got && w_got) begin
                for (int b = 0; b < bridge_pkg::strb_w; b++) begin
                    if (w_strb[b]) begin
                        mem[aw_addr[9:4]][8*b +: 8] <= w_data[8*b +: 8];
                    end
                end
                aw_got <= 1'b0;
                w_got  <= 1'b0;
                bvalid <= 1'b1;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

endmodule

//--- dv/tb_axi_cache_bridge.sv
`timescale 1ns/1ps

module tb_axi_cache_bridge;

    localparam int np        = bridge_pkg::num_ports;
    localparam int req_limit = 400;
    localparam int ret_limit = 400;
    // five tests, at most 38 accepted requests, one drain wait and 4 return waits
    localparam int test_cycles = 4 * ret_limit + 40 * req_limit;
    localparam int watchdog_ns = test_cycles * 4 + 1000;

    logic clk;
    logic reset;
    logic ar_stall, aw_stall, w_stall, stall_on;
    logic [15:0] lfsr;

    bridge_pkg::id_t               arid, rid;
    logic [bridge_pkg::addr_w-1:0] araddr, awaddr;
    logic [bridge_pkg::type_w-1:0] arsize, awsize;
    bridge_pkg::line_t             rdata, wdata;
    logic [bridge_pkg::strb_w-1:0] wstrb;
    logic arvalid, arready, rvalid, rready, awvalid, awready;
    logic wvalid, wready, bvalid, bready, write_buffer_empty;

    logic [np-1:0]                         rd_req, rd_rdy, wr_req, wr_rdy;
    logic [np-1:0]                         ret_valid, ret_ready;
    logic [np-1:0][bridge_pkg::type_w-1:0] rd_type, wr_type;
    logic [np-1:0][bridge_pkg::addr_w-1:0] rd_addr, wr_addr;
    logic [np-1:0][bridge_pkg::strb_w-1:0] wr_wstrb;
    logic [np-1:0][bridge_pkg::data_w-1:0] wr_data, ret_data;

    // expected memory image, updated in each port's request order
    bridge_pkg::line_t sb [64];
    bridge_pkg::line_t exp_q [np][$];
    bridge_pkg::line_t got_q [np][$];
    bridge_pkg::id_t   ar_ids [$];
    int value_errors;
    int timeouts;

    axi_cache_bridge u_axi_cache_bridge (.*);
    axi_mem_model u_axi_mem_model (.*);

    always #2 clk = ~clk;

    function automatic bridge_pkg::line_t fill_word(logic [31:0] a);
        return {a ^ 32'hc3c3_0003, a ^ 32'h3c3c_0002, a ^ 32'h0f0f_0001, a ^ 32'hf0f0_0000};
    endfunction

    // client type follows the line address, so each AR/AW size is predictable
    function automatic logic [bridge_pkg::type_w-1:0] type_for_addr(logic [31:0] a);
        return a[6:4];
    endfunction

    // galois form, taps 16/14/13/11
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hb400 : 16'h0000);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic void expect_eq(string sig, logic [127:0] got, logic [127:0] exp);
        assert (got === exp) else begin
            value_errors++;
            $display("ERROR at %0d ns: %s expected %h, got %h", $time, sig, exp, got);
        end
    endfunction

    always @(posedge clk) begin
        if (stall_on) begin
            ar_stall  <= (rand_bits(1) != 0);
            aw_stall  <= (rand_bits(1) != 0);
            w_stall   <= (rand_bits(1) != 0);
            ret_ready <= np'(rand_bits(np));
        end else begin
            ar_stall  <= 1'b0;
            aw_stall  <= 1'b0;
            w_stall   <= 1'b0;
            ret_ready <= '1;
        end
    end

    // handshakes are sampled mid-cycle where everything has settled
    always @(negedge clk) begin
        if (!reset) begin
            for (int p = 0; p < np; p++) begin
                if (ret_valid[p] && ret_ready[p]) begin
                    got_q[p].push_back(ret_data[p]);
                end
            end
            if (arvalid && arready) begin
                ar_ids.push_back(arid);
                expect_eq("arsize", 128'(arsize), 128'(type_for_addr(araddr)));
            end
            if (awvalid && awready) begin
                expect_eq("awsize", 128'(awsize), 128'(type_for_addr(awaddr)));
            end
        end
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, tests did not finish", watchdog_ns);
        $display("=== FAIL ===");
        $finish;
    end

    task automatic send_req(int p, bit wr, logic [31:0] a, logic [15:0] s,
                            bridge_pkg::line_t d);
        int waited;
        logic [5:0] w;
        waited = 0;
        w = a[9:4];
        @(posedge clk);
        if (wr) begin
            wr_req[p]   <= 1'b1;
            wr_type[p]  <= type_for_addr(a);
            wr_addr[p]  <= a;
            wr_wstrb[p] <= s;
            wr_data[p]  <= d;
        end else begin
            rd_req[p]  <= 1'b1;
            rd_type[p] <= type_for_addr(a);
            rd_addr[p] <= a;
        end
        @(negedge clk);
        while (!(wr ? wr_rdy[p] : rd_rdy[p]) && waited < req_limit) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= req_limit) begin
            timeouts++;
            $display("timeout: port %0d request to %h was never accepted", p, a);
        end
        // handshake edge
        @(posedge clk);
        wr_req[p] <= 1'b0;
        rd_req[p] <= 1'b0;
        if (wr) begin
            for (int b = 0; b < 16; b++) begin
                if (s[b]) begin
                    sb[w][8*b +: 8] = d[8*b +: 8];
                end
            end
        end else begin
            exp_q[p].push_back(sb[w]);
        end
    endtask

    task automatic collect_returns();
        int waited;
        bridge_pkg::line_t got;
        bridge_pkg::line_t exp;
        waited = 0;
        while ((got_q[0].size() < exp_q[0].size() || got_q[1].size() < exp_q[1].size())
               && waited < ret_limit) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= ret_limit) begin
            timeouts++;
            $display("timeout: read data still missing after %0d cycles", ret_limit);
        end
        // a stray or duplicated beat would land here
        repeat (20) @(negedge clk);
        for (int p = 0; p < np; p++) begin
            expect_eq($sformatf("return count port %0d", p), 128'(got_q[p].size()),
                      128'(exp_q[p].size()));
            while (got_q[p].size() > 0 && exp_q[p].size() > 0) begin
                got = got_q[p].pop_front();
                exp = exp_q[p].pop_front();
                expect_eq($sformatf("ret_data[%0d]", p), got, exp);
            end
            got_q[p].delete();
            exp_q[p].delete();
        end
    endtask

    task automatic reset_values();
        @(negedge clk);
        expect_eq("arvalid", 128'(arvalid), 128'(1'b0));
        expect_eq("awvalid", 128'(awvalid), 128'(1'b0));
        expect_eq("wvalid", 128'(wvalid), 128'(1'b0));
        expect_eq("bready", 128'(bready), 128'(1'b0));
        expect_eq("ret_valid", 128'(ret_valid), 128'(2'b00));
        expect_eq("rready", 128'(rready), 128'(1'b1));
        expect_eq("write_buffer_empty", 128'(write_buffer_empty), 128'(1'b1));
        expect_eq("rd_rdy", 128'(rd_rdy), 128'(2'b11));
        expect_eq("wr_rdy", 128'(wr_rdy), 128'(2'b11));
    endtask

    task automatic read_each_port();
        send_req(0, 1'b0, 32'h0000_0040, '0, '0);
        send_req(1, 1'b0, 32'h0000_0250, '0, '0);
        collect_returns();
    endtask

    task automatic write_then_read();
        int waited;
        waited = 0;
        send_req(1, 1'b1, 32'h0000_0130, 16'h0ff0, {4{32'h1234_5678}});
        @(negedge clk);
        expect_eq("write_buffer_empty", 128'(write_buffer_empty), 128'(1'b0));
        send_req(0, 1'b0, 32'h0000_0130, '0, '0);
        while (!write_buffer_empty && waited < req_limit) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= req_limit) begin
            timeouts++;
            $display("timeout: write_buffer_empty never came back high after the write");
        end
        expect_eq("ret_valid[0]", 128'(ret_valid[0]), 128'(1'b0));
        expect_eq("beats before write drained", 128'(got_q[0].size()), 128'(0));
        collect_returns();
    endtask

    task automatic read_both_ports();
        ar_ids.delete();
        fork
            send_req(0, 1'b0, 32'h0000_0080, '0, '0);
            send_req(1, 1'b0, 32'h0000_0390, '0, '0);
        join
        collect_returns();
        expect_eq("AR handshake count", 128'(ar_ids.size()), 128'(2));
        if (ar_ids.size() == 2) begin
            expect_eq("arid of first AR", 128'(ar_ids[0]), 128'(1));
            expect_eq("arid of second AR", 128'(ar_ids[1]), 128'(0));
        end
    endtask

    // each port stays in its own 256-byte window
    task automatic port_traffic(int p);
        logic [31:0] a;
        logic [15:0] s;
        bridge_pkg::line_t d;
        for (int n = 0; n < 16; n++) begin
            a = 32'(p * 256) + (rand_bits(4) << 4);
            if (rand_bits(1) != 0) begin
                s = 16'(rand_bits(16));
                d = {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)};
                send_req(p, 1'b1, a, s, d);
            end else begin
                send_req(p, 1'b0, a, '0, '0);
            end
        end
    endtask

    task automatic stalled_traffic();
        @(posedge clk);
        stall_on <= 1'b1;
        fork
            port_traffic(0);
            port_traffic(1);
        join
        collect_returns();
        @(posedge clk);
        stall_on <= 1'b0;
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        lfsr         = 16'd45;
        stall_on     = 1'b0;
        ar_stall     = 1'b0;
        aw_stall     = 1'b0;
        w_stall      = 1'b0;
        rd_req       = '0;
        wr_req       = '0;
        ret_ready    = '1;
        rd_type      = {np{3'd4}};
        wr_type      = {np{3'd4}};
        rd_addr      = '0;
        wr_addr      = '0;
        wr_wstrb     = '0;
        wr_data      = '0;
        value_errors = 0;
        timeouts     = 0;
        for (int i = 0; i < 64; i++) begin
            sb[i] = fill_word(32'(i * 16));
        end
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        reset_values();
        read_each_port();
        write_then_read();
        read_both_ports();
        stalled_traffic();
        $display("summary: %0d value errors, %0d timeouts", value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- tb.f
verilog/bridge_pkg.sv
verilog/cache_req_if.sv
verilog/cache_port.sv
verilog/axi_req_engine.sv
verilog/rd_return_router.sv
verilog/axi_cache_bridge.sv
dv/axi_mem_model.sv
dv/tb_axi_cache_bridge.sv

//--- verilog/axi_cache_bridge.sv
`timescale 1ns/1ps

module axi_cache_bridge (
    input  logic                                                clk,
    input  logic                                                reset,

    output bridge_pkg::id_t                                     arid,
    output logic [bridge_pkg::addr_w-1:0]                       araddr,
    output logic [bridge_pkg::type_w-1:0]                       arsize,
    output logic                                                arvalid,
    input  logic                                                arready,

    input  bridge_pkg::id_t                                     rid,
    input  bridge_pkg::line_t                                   rdata,
    input  logic                                                rvalid,
    output logic                                                rready,

    output logic [bridge_pkg::addr_w-1:0]                       awaddr,
    output logic [bridge_pkg::type_w-1:0]                       awsize,
    output logic                                                awvalid,
    input  logic                                                awready,

    output bridge_pkg::line_t                                   wdata,
    output logic [bridge_pkg::strb_w-1:0]                       wstrb,
    output logic                                                wvalid,
    input  logic                                                wready,

    input  logic                                                bvalid,
    output logic                                                bready,

    // client side, one slice per port
    input  logic [bridge_pkg::num_ports-1:0]                    rd_req,
    input  logic [bridge_pkg::num_ports-1:0][bridge_pkg::type_w-1:0] rd_type,
    input  logic [bridge_pkg::num_ports-1:0][bridge_pkg::addr_w-1:0] rd_addr,
    output logic [bridge_pkg::num_ports-1:0]                    rd_rdy,
    output logic [bridge_pkg::num_ports-1:0]                    ret_valid,
    output logic [bridge_pkg::num_ports-1:0][bridge_pkg::data_w-1:0] ret_data,
    input  logic [bridge_pkg::num_ports-1:0]                    ret_ready,
    input  logic [bridge_pkg::num_ports-1:0]                    wr_req,
    input  logic [bridge_pkg::num_ports-1:0][bridge_pkg::type_w-1:0] wr_type,
    input  logic [bridge_pkg::num_ports-1:0][bridge_pkg::addr_w-1:0] wr_addr,
    input  logic [bridge_pkg::num_ports-1:0][bridge_pkg::strb_w-1:0] wr_wstrb,
    input  logic [bridge_pkg::num_ports-1:0][bridge_pkg::data_w-1:0] wr_data,
    output logic [bridge_pkg::num_ports-1:0]                    wr_rdy,
    output logic                                                write_buffer_empty
);

    cache_req_if req_bus [bridge_pkg::num_ports] ();

    for (genvar g = 0; g < bridge_pkg::num_ports; g++) begin : g_port
        cache_port u_cache_port (
            .clk       (clk),
            .reset     (reset),
            .rd_req    (rd_req[g]),
            .rd_type   (rd_type[g]),
            .rd_addr   (rd_addr[g]),
            .rd_rdy    (rd_rdy[g]),
            .wr_req    (wr_req[g]),
            .wr_type   (wr_type[g]),
            .wr_addr   (wr_addr[g]),
            .wr_wstrb  (wr_wstrb[g]),
            .wr_data   (wr_data[g]),
            .wr_rdy    (wr_rdy[g]),
            .ret_valid (ret_valid[g]),
            .ret_data  (ret_data[g]),
            .ret_ready (ret_ready[g]),
            .bus       (req_bus[g])
        );
    end

    // drains the holding registers onto AR or AW/W
    axi_req_engine u_axi_req_engine (
        .clk                (clk),
        .reset              (reset),
        .arid               (arid),
        .araddr             (araddr),
        .arsize             (arsize),
        .arvalid            (arvalid),
        .arready            (arready),
        .awaddr             (awaddr),
        .awsize             (awsize),
        .awvalid            (awvalid),
        .awready            (awready),
        .wdata              (wdata),
        .wstrb              (wstrb),
        .wvalid             (wvalid),
        .wready             (wready),
        .bvalid             (bvalid),
        .bready             (bready),
        .write_buffer_empty (write_buffer_empty),
        .ports              (req_bus)
    );

    rd_return_router u_rd_return_router (
        .clk    (clk),
        .reset  (reset),
        .rid    (rid),
        .rdata  (rdata),
        .rvalid (rvalid),
        .rready (rready),
        .ports  (req_bus)
    );

endmodule

//--- verilog/axi_req_engine.sv
`timescale 1ns/1ps

module axi_req_engine (
    input  logic                          clk,
    input  logic                          reset,
    output bridge_pkg::id_t               arid,
    output logic [bridge_pkg::addr_w-1:0] araddr,
    output logic [bridge_pkg::type_w-1:0] arsize,
    output logic                          arvalid,
    input  logic                          arready,
    output logic [bridge_pkg::addr_w-1:0] awaddr,
    output logic [bridge_pkg::type_w-1:0] awsize,
    output logic                          awvalid,
    input  logic                          awready,
    output bridge_pkg::line_t             wdata,
    output logic [bridge_pkg::strb_w-1:0] wstrb,
    output logic                          wvalid,
    input  logic                          wready,
    input  logic                          bvalid,
    output logic                          bready,
    output logic                          write_buffer_empty,
    cache_req_if.engine                   ports [bridge_pkg::num_ports]
);

    bridge_pkg::eng_state_t state;

    logic [bridge_pkg::num_ports-1:0] req_v;
    logic [bridge_pkg::num_ports-1:0] held_wr_v;
    bridge_pkg::req_op_t              op_v    [bridge_pkg::num_ports];
    logic [bridge_pkg::addr_w-1:0]    addr_v  [bridge_pkg::num_ports];
    logic [bridge_pkg::type_w-1:0]    size_v  [bridge_pkg::num_ports];
    logic [bridge_pkg::strb_w-1:0]    wstrb_v [bridge_pkg::num_ports];
    bridge_pkg::line_t                wdata_v [bridge_pkg::num_ports];

    logic                          sel_valid;
    bridge_pkg::id_t               sel_id;
    bridge_pkg::req_op_t           sel_op;
    logic [bridge_pkg::addr_w-1:0] sel_addr;
    logic [bridge_pkg::type_w-1:0] sel_size;
    logic [bridge_pkg::strb_w-1:0] sel_wstrb;
    bridge_pkg::line_t             sel_wdata;

    logic write_pending;
    logic b_hs;
    logic grant;

    for (genvar g = 0; g < bridge_pkg::num_ports; g++) begin : g_port
        assign req_v[g]     = ports[g].req;
        assign op_v[g]      = ports[g].op;
        assign addr_v[g]    = ports[g].addr;
        assign size_v[g]    = ports[g].size;
        assign wstrb_v[g]   = ports[g].wstrb;
        assign wdata_v[g]   = ports[g].wdata;
        assign held_wr_v[g] = ports[g].req && (ports[g].op == bridge_pkg::op_write);
        assign ports[g].ack = grant && (sel_id == bridge_pkg::id_t'(g));
    end

    // ascending scan, so the highest requesting index ends up selected
    always_comb begin
        sel_valid = 1'b0;
        sel_id    = '0;
        sel_op    = bridge_pkg::op_read;
        sel_addr  = '0;
        sel_size  = '0;
        sel_wstrb = '0;
        sel_wdata = '0;
        for (int i = 0; i < bridge_pkg::num_ports; i++) begin
            if (req_v[i]) begin
                sel_valid = 1'b1;
                sel_id    = bridge_pkg::id_t'(i);
                sel_op    = op_v[i];
                sel_addr  = addr_v[i];
                sel_size  = size_v[i];
                sel_wstrb = wstrb_v[i];
                sel_wdata = wdata_v[i];
            end
        end
    end

    assign b_hs = bvalid && bready;
    // nothing leaves while a write response is out, B in this cycle frees it
    assign grant = (state == bridge_pkg::eng_idle) && sel_valid && (!write_pending || b_hs);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= bridge_pkg::eng_idle;
            arvalid <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
        end else begin
            case (state)
                bridge_pkg::eng_idle: begin
                    if (grant && sel_op == bridge_pkg::op_write) begin
                        state   <= bridge_pkg::eng_aw_w;
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                    end else if (grant) begin
                        state   <= bridge_pkg::eng_ar;
                        arvalid <= 1'b1;
                    end
                end
                bridge_pkg::eng_ar: begin
                    if (arready) begin
                        state   <= bridge_pkg::eng_idle;
                        arvalid <= 1'b0;
                    end
                end
                bridge_pkg::eng_aw_w: begin
                    if (awready && wready) begin
                        state   <= bridge_pkg::eng_idle;
                        awvalid <= 1'b0;
                        wvalid  <= 1'b0;
                    end else if (awready) begin
                        state   <= bridge_pkg::eng_w_only;
                        awvalid <= 1'b0;
                    end else if (wready) begin
                        state  <= bridge_pkg::eng_aw_only;
                        wvalid <= 1'b0;
                    end
                end
                bridge_pkg::eng_aw_only: begin
                    if (awready) begin
                        state   <= bridge_pkg::eng_idle;
                        awvalid <= 1'b0;
                    end
                end
                bridge_pkg::eng_w_only: begin
                    if (wready) begin
                        state  <= bridge_pkg::eng_idle;
                        wvalid <= 1'b0;
                    end
                end
                default: state <= bridge_pkg::eng_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (grant && sel_op == bridge_pkg::op_write) begin
            awaddr <= sel_addr;
            awsize <= sel_size;
            wdata  <= sel_wdata;
            wstrb  <= sel_wstrb;
        end else if (grant) begin
            arid   <= sel_id;
            araddr <= sel_addr;
            arsize <= sel_size;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            write_pending <= 1'b0;
        end else if (grant && sel_op == bridge_pkg::op_write) begin
            write_pending <= 1'b1;
        end else if (b_hs) begin
            write_pending <= 1'b0;
        end
    end

    assign bready             = write_pending;
    assign write_buffer_empty = !write_pending && !(|held_wr_v);

    ar_aw_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        arvalid |-> !awvalid && !wvalid
    );

    b_needs_write: assert property (
        @(posedge clk) disable iff (reset)
        bvalid |-> write_pending
    );

endmodule

//--- verilog/bridge_pkg.sv
package bridge_pkg;

    // client count, index 1 is the data cache and wins arbitration
    localparam int num_ports = 2;

    localparam int addr_w = 32;
    localparam int data_w = 128;
    localparam int strb_w = data_w / 8;
    localparam int id_w   = 4;
    localparam int type_w = 3;

    typedef logic [data_w-1:0] line_t;
    // AXI id carries the port index
    typedef logic [id_w-1:0] id_t;

    typedef enum logic {
        op_read,
        op_write
    } req_op_t;

    typedef enum logic [2:0] {
        eng_idle,
        eng_ar,
        eng_aw_w,
        // one of AW/W has been accepted, waiting on the other
        eng_aw_only,
        eng_w_only
    } eng_state_t;

    typedef enum logic {
        port_empty,
        port_full
    } port_state_t;

endpackage

//--- verilog/cache_port.sv
`timescale 1ns/1ps

module cache_port (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          rd_req,
    input  logic [bridge_pkg::type_w-1:0] rd_type,
    input  logic [bridge_pkg::addr_w-1:0] rd_addr,
    output logic                          rd_rdy,
    input  logic                          wr_req,
    input  logic [bridge_pkg::type_w-1:0] wr_type,
    input  logic [bridge_pkg::addr_w-1:0] wr_addr,
    input  logic [bridge_pkg::strb_w-1:0] wr_wstrb,
    input  logic [bridge_pkg::data_w-1:0] wr_data,
    output logic                          wr_rdy,
    output logic                          ret_valid,
    output bridge_pkg::line_t             ret_data,
    input  logic                          ret_ready,
    cache_req_if.port                     bus
);

    bridge_pkg::port_state_t hold_state;
    logic take_wr;
    logic take_rd;
    logic ret_full;
    logic ret_take;

    assign wr_rdy = (hold_state == bridge_pkg::port_empty);
    // write goes first when both show up
    assign rd_rdy  = wr_rdy && !wr_req;
    assign take_wr = wr_req && wr_rdy;
    assign take_rd = rd_req && rd_rdy;

    always_ff @(posedge clk) begin
        if (reset) begin
            hold_state <= bridge_pkg::port_empty;
        end else if (take_wr || take_rd) begin
            hold_state <= bridge_pkg::port_full;
        end else if (bus.req && bus.ack) begin
            hold_state <= bridge_pkg::port_empty;
        end
    end

    // held request, size passes straight through from type
    always_ff @(posedge clk) begin
        if (take_wr) begin
            bus.op    <= bridge_pkg::op_write;
            bus.addr  <= wr_addr;
            bus.size  <= wr_type;
            bus.wstrb <= wr_wstrb;
            bus.wdata <= wr_data;
        end else if (take_rd) begin
            bus.op   <= bridge_pkg::op_read;
            bus.addr <= rd_addr;
            bus.size <= rd_type;
        end
    end

    assign bus.req = (hold_state == bridge_pkg::port_full);

    // one-beat return buffer, refills in the cycle it drains
    assign bus.ret_space = !ret_full || ret_ready;
    assign ret_take      = bus.ret_valid && bus.ret_space;

    always_ff @(posedge clk) begin
        if (reset) begin
            ret_full <= 1'b0;
        end else if (ret_take) begin
            ret_full <= 1'b1;
        end else if (ret_ready) begin
            ret_full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ret_take) begin
            ret_data <= bus.ret_data;
        end
    end

    assign ret_valid = ret_full;

    held_req_stable: assert property (
        @(posedge clk) disable iff (reset)
        bus.req && !bus.ack |=> bus.req && $stable(bus.op) && $stable(bus.addr)
            && $stable(bus.size) && $stable(bus.wstrb) && $stable(bus.wdata)
    );

endmodule

//--- verilog/cache_req_if.sv
`timescale 1ns/1ps

interface cache_req_if;

    // request from a port to the engine
    logic                                req;
    bridge_pkg::req_op_t                 op;
    logic [bridge_pkg::addr_w-1:0]       addr;
    logic [bridge_pkg::type_w-1:0]       size;
    logic [bridge_pkg::strb_w-1:0]       wstrb;
    bridge_pkg::line_t                   wdata;
    logic                                ack;

    // routed read beat back to the port
    logic                                ret_valid;
    bridge_pkg::line_t                   ret_data;
    logic                                ret_space;

    modport port (
        output req, op, addr, size, wstrb, wdata,
        input  ack,
        input  ret_valid, ret_data,
        output ret_space
    );

    modport engine (
        input  req, op, addr, size, wstrb, wdata,
        output ack
    );

    modport router (
        output ret_valid, ret_data,
        input  ret_space
    );

endinterface

//--- verilog/rd_return_router.sv
`timescale 1ns/1ps

module rd_return_router (
    input  logic              clk,
    input  logic              reset,
    input  bridge_pkg::id_t   rid,
    input  bridge_pkg::line_t rdata,
    input  logic              rvalid,
    output logic              rready,
    cache_req_if.router       ports [bridge_pkg::num_ports]
);

    logic                             beat_valid;
    bridge_pkg::id_t                  beat_id;
    bridge_pkg::line_t                beat_data;
    logic [bridge_pkg::num_ports-1:0] taken_v;
    logic                             beat_taken;

    // offer the beat only to the port its id names
    for (genvar g = 0; g < bridge_pkg::num_ports; g++) begin : g_port
        assign ports[g].ret_valid = beat_valid && (beat_id == bridge_pkg::id_t'(g));
        assign ports[g].ret_data  = beat_data;
        assign taken_v[g]         = ports[g].ret_valid && ports[g].ret_space;
    end

    assign beat_taken = |taken_v;
    assign rready     = !beat_valid || beat_taken;

    always_ff @(posedge clk) begin
        if (reset) begin
            beat_valid <= 1'b0;
        end else if (rvalid && rready) begin
            beat_valid <= 1'b1;
        end else if (beat_taken) begin
            beat_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rvalid && rready) begin
            beat_id   <= rid;
            beat_data <= rdata;
        end
    end

    rid_in_range: assert property (
        @(posedge clk) disable iff (reset)
        rvalid |-> rid < bridge_pkg::num_ports
    );

endmodule
